// ==== sensorIo.f ====
robotPkg.sv
inputSync.sv
encoderChannel.sv
speedBank.sv
beaconFilter.sv
sensorRegs.sv
sensorIo.sv
sensorIo_check.sv
sensorIo_tb.sv

// ==== Bender.yml ====
package:
  name: sensorIo

sources:
  - robotPkg.sv
  - inputSync.sv
  - encoderChannel.sv
  - speedBank.sv
  - beaconFilter.sv
  - sensorRegs.sv
  - sensorIo.sv
  - target: simulation
    files:
      - sensorIo_check.sv
      - sensorIo_tb.sv

// ==== sensorIo_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module sensorIo_tb import robotPkg::*; ();

	localparam int windowLen = 200;     // short window, every period divides it
	localparam int laserPeriod = 8;
	localparam int stepLimit = 320;

	logic clk = 1'b0;
	logic reset;
	encPins_t enc;
	laserPins_t laser;
	switch_t switchLevels;
	logic startLevel;
	logic idLevel;
	sensorRegs_t regs;

	logic checkEn;
	sensorRegs_t expected;
	int errorCount;
	int checkCount;

	int seed;
	int tick;
	int edgeCount;      // laserA rises since the last sync pulse
	int timeouts;
	axisMask_t bLead;   // one bit per axis, B ahead of A
	logic syncLevel;
	logic signLevel;
	logic turn;
	count_t lastStart;
	count_t lastEnd;
	int period [axisCount] = '{10, 20, 25, 40, 50, 100, 200};

	always #5 clk = ~clk;

	sensorIo #(.windowCycles(windowLen)) i_dut (
		.clk(clk),
		.reset(reset),
		.enc(enc),
		.laser(laser),
		.switches(switchLevels),
		.start(startLevel),
		.id(idLevel),
		.regs(regs)
	);

	sensorIo_check i_check (
		.clk(clk),
		.checkEn(checkEn),
		.expected(expected),
		.regs(regs),
		.errorCount(errorCount),
		.checkCount(checkCount)
	);

	// ============================================================
	// reference model
	// ============================================================
	function automatic sensorRegs_t expectRegs(input axisMask_t leads, input switch_t sw,
		input logic st, input logic idBit, input logic turnBit,
		input count_t bStart, input count_t bEnd);
		sensorRegs_t exp;
		int i;
		exp = '0;
		exp.flags[0] = idBit;
		exp.flags[7:1] = leads ^ dirInvert;   // B leading reads as forward
		exp.flags[12:8] = sw;
		exp.flags[13] = st;
		exp.flags[15] = turnBit;
		for (i = 0; i < axisCount; i++) begin
			exp.speeds[i] = count_t'(windowLen / period[i]);  // A and B see the same count
		end
		exp.towerSpeed = count_t'(windowLen / laserPeriod);
		exp.beaconStart = bStart;
		exp.beaconEnd = bEnd;
		return exp;
	endfunction

	// ============================================================
	// stimulus
	// ============================================================
	// one clock of pin activity, driven on the falling edge
	task automatic stepCycle();
		int i;
		int half;
		int quarter;
		logic laserA;
		@(negedge clk);
		tick++;
		for (i = 0; i < axisCount; i++) begin
			half = period[i] / 2;
			quarter = period[i] / 4;
			enc.a[i] = (tick % period[i]) < half;
			if (bLead[i]) begin
				enc.b[i] = ((tick + quarter) % period[i]) < half;
			end else begin
				enc.b[i] = ((tick + period[i] - quarter) % period[i]) < half;
			end
		end
		laserA = (tick % laserPeriod) < laserPeriod / 2;
		if (laserA && !laser.encA) begin
			edgeCount++;
		end
		laser.encA = laserA;
		laser.sync = syncLevel;
		laser.sign = signLevel;
	endtask

	task automatic waitCycles(input int n);
		repeat (n) stepCycle();
	endtask

	task automatic noteTimeout(input string what);
		$display("timeout while waiting for %s at %0t", what, $time);
		timeouts++;
	endtask

	// stops one step before a laserA midpoint, n < 0 takes any edge count
	task automatic advanceTo(input int n);
		int steps;
		steps = 0;
		while (!((n < 0 || edgeCount == n) && (tick + 1) % laserPeriod == laserPeriod / 2)
			&& steps < stepLimit) begin
			stepCycle();
			steps++;
		end
		if (steps >= stepLimit) begin
			noteTimeout($sformatf("tower angle %0d", n));
		end
	endtask

	task automatic requestCheck(input sensorRegs_t exp);
		expected = exp;
		checkEn = 1'b1;
		stepCycle();
		checkEn = 1'b0;
	endtask

	task automatic runBeaconPass(input int s);
		int e;
		int steps;
		logic prevTurn;
		e = s + 20;
		prevTurn = regs.flags[15];
		advanceTo(-1);
		syncLevel = 1'b1;
		stepCycle();
		edgeCount = 0;
		stepCycle();
		syncLevel = 1'b0;
		steps = 0;
		while (regs.flags[15] == prevTurn && steps < 20) begin
			stepCycle();
			steps++;
		end
		if (regs.flags[15] == prevTurn) begin
			noteTimeout("the revolution flag to toggle");
		end
		advanceTo(s);
		signLevel = 1'b1;
		stepCycle();
		advanceTo(s + 6);
		signLevel = 1'b0;     // short dropout of five edges
		stepCycle();
		advanceTo(s + 11);
		signLevel = 1'b1;
		stepCycle();
		advanceTo(e);
		signLevel = 1'b0;
		stepCycle();
		steps = 0;
		while (regs.beaconStart == lastStart && regs.beaconEnd == lastEnd
			&& steps < stepLimit) begin
			stepCycle();
			steps++;
		end
		if (regs.beaconStart == lastStart && regs.beaconEnd == lastEnd) begin
			noteTimeout("the beacon angles to be published");
		end
		turn = ~turn;
		requestCheck(expectRegs(bLead, switchLevels, startLevel, idLevel, turn,
			count_t'(s), count_t'(e)));
		lastStart = count_t'(s);
		lastEnd = count_t'(e);
	endtask

	// ============================================================
	// sequence
	// ============================================================
	initial begin
		int pass;
		seed = 3;
		tick = 0;
		edgeCount = 0;
		timeouts = 0;
		reset = 1'b1;
		enc = '0;
		laser = '0;
		switchLevels = '0;
		startLevel = 1'b0;
		idLevel = 1'b0;
		checkEn = 1'b0;
		expected = '0;
		syncLevel = 1'b0;
		signLevel = 1'b0;
		turn = 1'b0;
		lastStart = '0;
		lastEnd = '0;
		bLead = 7'b101_0011;

		repeat (3) stepCycle();
		reset = 1'b0;
		requestCheck('0);

		switchLevels = $random(seed);
		startLevel = $random(seed);
		idLevel = $random(seed);
		waitCycles(3 * windowLen + 20);
		requestCheck(expectRegs(bLead, switchLevels, startLevel, idLevel, turn, '0, '0));

		// reversed lead, the window with the phase jump is skipped
		bLead = ~bLead;
		switchLevels = $random(seed);
		startLevel = $random(seed);
		idLevel = $random(seed);
		waitCycles(3 * windowLen + 20);
		requestCheck(expectRegs(bLead, switchLevels, startLevel, idLevel, turn, '0, '0));

		for (pass = 1; pass <= 2; pass++) begin
			runBeaconPass(4 * pass + ($random(seed) & 3));
		end

		waitCycles(2);
		$display("closing: %0d checks, %0d mismatches, %0d timeouts",
			checkCount, errorCount, timeouts);
		if (errorCount == 0 && timeouts == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sensorIo_check.sv ====
`timescale 1ns/1ps
`default_nettype none

// compares the host words against the expected set on request
module sensorIo_check import robotPkg::*; (
	input wire logic clk,
	input wire logic checkEn,
	input wire sensorRegs_t expected,
	input wire sensorRegs_t regs,
	output int errorCount,
	output int checkCount
);

	int errors = 0;
	int checks = 0;

	assign errorCount = errors;
	assign checkCount = checks;

	task automatic compareWord(input string name, input word_t got, input word_t want);
		if (got !== want) begin
			$display("FAIL %s expected %h got %h at %0t", name, want, got, $time);
			errors++;
		end
	endtask

	// ============================================================
	// compare process
	// ============================================================
	// regs read here still hold the value of the cycle before the edge
	always @(posedge clk) begin
		if (checkEn) begin
			checks++;
			compareWord("regs.flags", regs.flags, expected.flags);
			for (int i = 0; i < axisCount; i++) begin
				compareWord($sformatf("regs.speeds[%0d]", i), regs.speeds[i],
					expected.speeds[i]);
			end
			compareWord("regs.towerSpeed", regs.towerSpeed, expected.towerSpeed);
			compareWord("regs.beaconStart", regs.beaconStart, expected.beaconStart);
			compareWord("regs.beaconEnd", regs.beaconEnd, expected.beaconEnd);
		end
	end

endmodule

`default_nettype wire

// ==== sensorIo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sensorIo import robotPkg::*; #(
	parameter int windowCycles = speedWindowCycles
) (
	input wire logic clk,
	input wire logic reset,
	input wire encPins_t enc,
	input wire laserPins_t laser,
	input wire switch_t switches,
	input wire logic start,
	input wire logic id,
	output sensorRegs_t regs
);

	edges_t edges;
	speeds_t speeds;
	axisMask_t forward;
	count_t towerSpeed;
	count_t beaconStart;
	count_t beaconEnd;
	logic towerTurn;

	// ============================================================
	// pin sampling
	// ============================================================
	inputSync sync (
		.clk(clk),
		.reset(reset),
		.enc(enc),
		.laser(laser),
		.switches(switches),
		.start(start),
		.id(id),
		.edges(edges)
	);

	// ============================================================
	// measurement
	// ============================================================
	speedBank #(.windowCycles(windowCycles)) speed (
		.clk(clk),
		.reset(reset),
		.edges(edges),
		.speeds(speeds),
		.forward(forward),
		.towerSpeed(towerSpeed)
	);

	beaconFilter beacon (
		.clk(clk),
		.reset(reset),
		.edges(edges),
		.beaconStart(beaconStart),
		.beaconEnd(beaconEnd),
		.towerTurn(towerTurn)
	);

	// host-visible words
	sensorRegs hostRegs (
		.clk(clk),
		.reset(reset),
		.edges(edges),
		.speeds(speeds),
		.forward(forward),
		.towerSpeed(towerSpeed),
		.beaconStart(beaconStart),
		.beaconEnd(beaconEnd),
		.towerTurn(towerTurn),
		.regs(regs)
	);

endmodule

`default_nettype wire

// ==== sensorRegs.sv ====
`timescale 1ns/1ps
`default_nettype none

module sensorRegs import robotPkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire edges_t edges,
	input wire speeds_t speeds,
	input wire axisMask_t forward,
	input wire count_t towerSpeed,
	input wire count_t beaconStart,
	input wire count_t beaconEnd,
	input wire logic towerTurn,
	output sensorRegs_t regs
);

	word_t flagWord;

	// id at bit 0, towerTurn at bit 15
	assign flagWord = {towerTurn, 1'b0, edges.start, edges.switches, forward, edges.id};

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			regs <= '0;
		end else begin
			regs.flags <= flagWord;
			regs.speeds <= speeds;
			regs.towerSpeed <= towerSpeed;
			regs.beaconStart <= beaconStart;
			regs.beaconEnd <= beaconEnd;
		end
	end

endmodule

`default_nettype wire

// ==== beaconFilter.sv ====
`timescale 1ns/1ps
`default_nettype none

module beaconFilter import robotPkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire edges_t edges,
	output count_t beaconStart,
	output count_t beaconEnd,
	output logic towerTurn
);

	count_t angle;          // tower edges since the last sync
	count_t startPending;
	count_t endPending;
	gapCount_t gapCount;
	beaconState_t state;
	logic gapDone;

	// last tower edge of a dropout long enough to end the reception
	assign gapDone = edges.laserA && (gapCount == gapCount_t'(beaconGapEdges - 1));

	// ============================================================
	// tower angle and revolution flag
	// ============================================================
	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			angle <= '0;
			towerTurn <= 1'b0;
		end else begin
			if (edges.laserSync) begin
				angle <= '0;           // sync wins over a coincident A edge
				towerTurn <= ~towerTurn;
			end else if (edges.laserA) begin
				angle <= angle + 1'b1;
			end
		end
	end

	// ============================================================
	// dropout FSM
	// ============================================================
	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			state <= waitBeacon;
			gapCount <= '0;
			beaconStart <= '0;
			beaconEnd <= '0;
		end else begin
			case (state)
				waitBeacon: begin
					if (edges.sign) begin
						state <= reception;
					end
				end
				reception: begin
					if (!edges.sign) begin
						gapCount <= '0;
						state <= gap;
					end
				end
				gap: begin
					if (edges.sign) begin
						state <= reception;    // short dropout, keep the start
					end else if (gapDone) begin
						beaconStart <= startPending;
						beaconEnd <= endPending;
						state <= waitBeacon;
					end else if (edges.laserA) begin
						gapCount <= gapCount + 1'b1;
					end
				end
				default: state <= waitBeacon;
			endcase
		end
	end

	// candidate angles, only published from gap
	always_ff @(posedge clk) begin
		if (state == waitBeacon && edges.sign) begin
			startPending <= angle;
		end
		if (state == reception && !edges.sign) begin
			endPending <= angle;
		end
	end

	stateLegal: assert property (
		@(posedge clk) disable iff (reset)
		state inside {waitBeacon, reception, gap}
	);

endmodule

`default_nettype wire

// ==== speedBank.sv ====
`timescale 1ns/1ps
`default_nettype none

module speedBank import robotPkg::*; #(
	parameter int windowCycles = speedWindowCycles
) (
	input wire logic clk,
	input wire logic reset,
	input wire edges_t edges,
	output speeds_t speeds,
	output axisMask_t forward,
	output count_t towerSpeed
);

	timer_t windowTimer;
	logic windowEnd;
	count_t towerCount;

	assign windowEnd = (windowTimer == timer_t'(windowCycles - 1));

	// free running from reset release
	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			windowTimer <= '0;
		end else if (windowEnd) begin
			windowTimer <= '0;
		end else begin
			windowTimer <= windowTimer + 1'b1;
		end
	end

	// tower speed is plain A edges, no averaging
	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			towerCount <= '0;
			towerSpeed <= '0;
		end else if (windowEnd) begin
			towerSpeed <= towerCount;
			towerCount <= count_t'(edges.laserA);
		end else begin
			towerCount <= towerCount + count_t'(edges.laserA);
		end
	end

	for (genvar i = 0; i < axisCount; i++) begin : gAxis
		encoderChannel channel (
			.clk(clk),
			.reset(reset),
			.aEdge(edges.encA[i]),
			.bEdge(edges.encB[i]),
			.bLevel(edges.encBLevel[i]),
			.windowEnd(windowEnd),
			.invert(dirInvert[i]),
			.speed(speeds[i]),
			.forward(forward[i])
		);
	end

	windowEndIsPulse: assert property (
		@(posedge clk) disable iff (reset)
		windowEnd |=> !windowEnd
	);

endmodule

`default_nettype wire

// ==== encoderChannel.sv ====
`timescale 1ns/1ps
`default_nettype none

// one quadrature axis
module encoderChannel import robotPkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire logic aEdge,
	input wire logic bEdge,
	input wire logic bLevel,
	input wire logic windowEnd,
	input wire logic invert,
	output count_t speed,
	output logic forward
);

	count_t aCount;
	count_t bCount;
	logic [$bits(count_t):0] edgeSum;   // one extra bit so the halving keeps the carry

	assign edgeSum = {1'b0, aCount} + {1'b0, bCount};

	// ============================================================
	// edge counters and speed
	// ============================================================
	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			aCount <= '0;
			bCount <= '0;
			speed <= '0;
		end else if (windowEnd) begin
			speed <= edgeSum[$bits(count_t):1]; // floor of the mean
			// an edge on the closing cycle starts the next window
			aCount <= count_t'(aEdge);
			bCount <= count_t'(bEdge);
		end else begin
			aCount <= aCount + count_t'(aEdge);
			bCount <= bCount + count_t'(bEdge);
		end
	end

	// ============================================================
	// direction
	// ============================================================
	// B already high when A rises means B leads
	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			forward <= 1'b0;
		end else if (aEdge) begin
			forward <= bLevel ^ invert;
		end
	end

	// the synchronizer only ever produces single-cycle pulses
	aEdgeIsPulse: assert property (
		@(posedge clk) disable iff (reset)
		aEdge |=> !aEdge
	);

endmodule

`default_nettype wire

// ==== inputSync.sv ====
`timescale 1ns/1ps
`default_nettype none

module inputSync import robotPkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire encPins_t enc,
	input wire laserPins_t laser,
	input wire switch_t switches,
	input wire logic start,
	input wire logic id,
	output edges_t edges
);

	typedef struct packed {
		logic id;
		logic start;
		switch_t sw;
		laserPins_t laser;
		encPins_t enc;
	} pinSet_t;

	pinSet_t pinsNow;
	pinSet_t meta;    // first flop, may go metastable
	pinSet_t stable;
	pinSet_t prev;    // one sample older, for edge detection

	assign pinsNow = '{id: id, start: start, sw: switches, laser: laser, enc: enc};

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			meta <= '0;
			stable <= '0;
			prev <= '0;
			edges <= '0;
		end else begin
			meta <= pinsNow;
			stable <= meta;
			prev <= stable;
			// pulses land three clocks after the pin moves
			edges.encA <= stable.enc.a & ~prev.enc.a;
			edges.encB <= stable.enc.b & ~prev.enc.b;
			edges.laserA <= stable.laser.encA & ~prev.laser.encA;
			edges.laserSync <= stable.laser.sync & ~prev.laser.sync;
			edges.encBLevel <= stable.enc.b;
			edges.sign <= stable.laser.sign;
			edges.switches <= stable.sw;
			edges.start <= stable.start;
			edges.id <= stable.id;
		end
	end

endmodule

`default_nettype wire

// ==== robotPkg.sv ====
`default_nettype none

package robotPkg;

	// ============================================================
	// sizes and constants
	// ============================================================
	localparam int axisCount = 7;
	localparam int switchCount = 5;
	localparam int speedWindowCycles = 500000;    // 10 ms at 50 MHz
	localparam int beaconGapEdges = 20;           // tower edges before a reception ends
	localparam int timerWidth = $clog2(speedWindowCycles + 1);
	localparam int gapWidth = $clog2(beaconGapEdges + 1);

	// axis order: propLeft, propRight, rakeLeft, rakeRight, gripper, odoLeft, odoRight
	typedef logic [axisCount-1:0] axisMask_t;
	typedef logic [15:0] word_t;
	typedef logic [15:0] count_t;                 // wraps
	typedef logic [timerWidth-1:0] timer_t;
	typedef logic [gapWidth-1:0] gapCount_t;

	// switch order: left, right, gripper, rakeLeft, rakeRight
	typedef logic [switchCount-1:0] switch_t;

	// propRight and odoLeft are mounted mirrored
	localparam axisMask_t dirInvert = 7'b010_0010;

	// ============================================================
	// bundles
	// ============================================================
	typedef struct packed {
		axisMask_t a;
		axisMask_t b;
	} encPins_t;

	typedef struct packed {
		logic encA;
		logic sync;
		logic sign;
	} laserPins_t;

	typedef struct packed {
		axisMask_t encA;      // rising edge pulses
		axisMask_t encB;
		logic laserA;
		logic laserSync;
		axisMask_t encBLevel; // synchronized levels from here down
		logic sign;
		switch_t switches;
		logic start;
		logic id;
	} edges_t;

	typedef count_t [axisCount-1:0] speeds_t;

	typedef enum logic [1:0] {
		waitBeacon,
		reception,
		gap
	} beaconState_t;

	typedef struct packed {
		word_t flags;
		speeds_t speeds;
		word_t towerSpeed;
		word_t beaconStart;
		word_t beaconEnd;
	} sensorRegs_t;

endpackage

`default_nettype wire
